/* hw/exec_pkg.sv */
package exec_pkg;

    // ************************************************************
    // opcodes.
    // ************************************************************
    typedef enum logic [3:0] {
        OP_ADD       = 4'd0,
        OP_SUB       = 4'd1,
        OP_SHL_ONES  = 4'd2,
        OP_SHR_ONES  = 4'd3,
        OP_MOVE      = 4'd4,
        OP_LOAD_HALF = 4'd5,
        OP_CMP_EQ    = 4'd8,
        OP_CMP_LT    = 4'd9,
        OP_CMP_GT    = 4'd10
    } alu_op_e;

    // immediate view of the b word.
    typedef struct packed {
        logic [14:0] unused;
        logic        high_half;
        logic [15:0] value;
    } load_imm_t;

    // b operand as a full word or a load-half immediate.
    typedef union packed {
        logic [31:0] word;
        load_imm_t   imm;
    } lane_operand_u;

    // ************************************************************
    // request and result words.
    // ************************************************************
    typedef struct packed {
        alu_op_e       op;
        logic [31:0]   a;
        lane_operand_u b;
    } alu_req_t;

    typedef struct packed {
        logic [31:0] data;
        logic        flag;
    } alu_result_t;

endpackage

/* hw/alu_lane.sv */
`timescale 1ns/10ps

module alu_lane
    import exec_pkg::*;
#(
    parameter int LANE_DEPTH = 2
)
(
    input  logic        clock,
    input  logic        reset,
    input  logic        issue_valid,
    input  alu_req_t    issue_req,
    output logic        head_valid,
    output alu_result_t head_result,
    input  logic        pop,
    output logic        lane_credit
);

    localparam int PTR_W = (LANE_DEPTH > 1) ? $clog2(LANE_DEPTH) : 1;
    localparam int CNT_W = $clog2(LANE_DEPTH + 1);

    logic             stage_valid;
    alu_req_t         stage_req;
    alu_result_t      stage_result;
    alu_result_t      fifo_mem [LANE_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] fifo_count;
    logic             push;
    logic             drain;

    // issue register.
    always_ff @(posedge clock)
    begin
        if (reset)
            stage_valid <= 1'b0;
        else
            stage_valid <= issue_valid;
    end

    always_ff @(posedge clock)
    begin
        if (issue_valid)
            stage_req <= issue_req;
    end

    // ************************************************************
    // datapath. shifts invert, shift, invert back so fill is ones.
    // ************************************************************
    always_comb
    begin
        stage_result = '0;
        case (stage_req.op)
            OP_ADD:      stage_result.data = stage_req.a + stage_req.b.word;
            OP_SUB:      stage_result.data = stage_req.a - stage_req.b.word;
            OP_SHL_ONES: stage_result.data = ~(~stage_req.a << stage_req.b.word);
            OP_SHR_ONES: stage_result.data = ~(~stage_req.a >> stage_req.b.word);
            OP_MOVE:     stage_result.data = stage_req.a;
            OP_LOAD_HALF:
            begin
                if (stage_req.b.imm.high_half)
                    stage_result.data = {stage_req.b.imm.value, stage_req.a[15:0]};
                else
                    stage_result.data = {stage_req.a[31:16], stage_req.b.imm.value};
            end
            OP_CMP_EQ:   stage_result.flag = (stage_req.a == stage_req.b.word);
            OP_CMP_LT:   stage_result.flag = (stage_req.a < stage_req.b.word);
            OP_CMP_GT:   stage_result.flag = (stage_req.a > stage_req.b.word);
            default:     stage_result = '0;
        endcase
    end

    // result FIFO, sized by the dispatcher's credits.
    assign push        = stage_valid;
    assign head_valid  = (fifo_count != '0);
    assign head_result = fifo_mem[rd_ptr];
    assign drain       = pop & head_valid;
    assign lane_credit = drain;

    always_ff @(posedge clock)
    begin
        if (push)
            fifo_mem[wr_ptr] <= stage_result;
    end

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            fifo_count <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= (wr_ptr == PTR_W'(LANE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (drain)
                rd_ptr <= (rd_ptr == PTR_W'(LANE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            case ({push, drain})
                2'b10:   fifo_count <= fifo_count + 1'b1;
                2'b01:   fifo_count <= fifo_count - 1'b1;
                default: fifo_count <= fifo_count;
            endcase
        end
    end

endmodule

/* hw/op_dispatcher.sv */
`timescale 1ns/10ps

module op_dispatcher
    import exec_pkg::*;
#(
    parameter int NUM_LANES  = 4,
    parameter int IN_DEPTH   = 4,
    parameter int LANE_DEPTH = 2
)
(
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 op_valid,
    input  alu_req_t             op,
    output logic                 op_credit,
    output logic [NUM_LANES-1:0] issue_valid,
    output alu_req_t             issue_req,
    input  logic [NUM_LANES-1:0] lane_credit
);

    localparam int QP_W  = (IN_DEPTH > 1) ? $clog2(IN_DEPTH) : 1;
    localparam int QC_W  = $clog2(IN_DEPTH + 1);
    localparam int LP_W  = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;
    localparam int LC_W  = $clog2(LANE_DEPTH + 1);

    alu_req_t        queue_mem [IN_DEPTH];
    logic [QP_W-1:0] q_wr_ptr;
    logic [QP_W-1:0] q_rd_ptr;
    logic [QC_W-1:0] q_count;
    logic [LP_W-1:0] issue_ptr;
    logic [LC_W-1:0] lane_cnt [NUM_LANES];
    logic            fire;

    // ************************************************************
    // issue decision, same cycle as head and credit.
    // ************************************************************
    assign fire      = (q_count != '0) && (lane_cnt[issue_ptr] != '0);
    assign op_credit = fire;
    assign issue_req = queue_mem[q_rd_ptr];

    always_comb
    begin
        for (int i = 0; i < NUM_LANES; i++)
            issue_valid[i] = fire && (issue_ptr == LP_W'(i));
    end

    always_ff @(posedge clock)
    begin
        if (op_valid)
            queue_mem[q_wr_ptr] <= op;
    end

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            q_wr_ptr  <= '0;
            q_rd_ptr  <= '0;
            q_count   <= '0;
            issue_ptr <= '0;
            for (int i = 0; i < NUM_LANES; i++)
                lane_cnt[i] <= LC_W'(LANE_DEPTH);
        end
        else
        begin
            if (op_valid)
                q_wr_ptr <= (q_wr_ptr == QP_W'(IN_DEPTH - 1)) ? '0 : q_wr_ptr + 1'b1;
            if (fire)
            begin
                q_rd_ptr  <= (q_rd_ptr == QP_W'(IN_DEPTH - 1)) ? '0 : q_rd_ptr + 1'b1;
                issue_ptr <= (issue_ptr == LP_W'(NUM_LANES - 1)) ? '0 : issue_ptr + 1'b1;
            end
            case ({op_valid, fire})
                2'b10:   q_count <= q_count + 1'b1;
                2'b01:   q_count <= q_count - 1'b1;
                default: q_count <= q_count;
            endcase
            // per-lane credits.
            for (int i = 0; i < NUM_LANES; i++)
            begin
                case ({issue_valid[i], lane_credit[i]})
                    2'b10:   lane_cnt[i] <= lane_cnt[i] - 1'b1;
                    2'b01:   lane_cnt[i] <= lane_cnt[i] + 1'b1;
                    default: lane_cnt[i] <= lane_cnt[i];
                endcase
            end
        end
    end

endmodule

/* hw/result_collector.sv */
`timescale 1ns/10ps

module result_collector
    import exec_pkg::*;
#(
    parameter int NUM_LANES   = 4,
    parameter int OUT_CREDITS = 2
)
(
    input  logic                 clock,
    input  logic                 reset,
    input  logic [NUM_LANES-1:0] head_valid,
    input  alu_result_t          head_result [NUM_LANES],
    output logic [NUM_LANES-1:0] pop,
    output logic                 result_valid,
    output alu_result_t          result,
    input  logic                 result_credit
);

    localparam int LP_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;
    localparam int OC_W = $clog2(OUT_CREDITS + 1);

    logic [LP_W-1:0] drain_ptr;
    logic [OC_W-1:0] credits;
    logic            take;

    // ************************************************************
    // drain in issue order. lane i gets op n when n mod lanes is i.
    // ************************************************************
    assign take = head_valid[drain_ptr] && (credits != '0);

    always_comb
    begin
        for (int i = 0; i < NUM_LANES; i++)
            pop[i] = take && (drain_ptr == LP_W'(i));
    end

    always_ff @(posedge clock)
    begin
        if (take)
            result <= head_result[drain_ptr];
    end

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            result_valid <= 1'b0;
            drain_ptr    <= '0;
            credits      <= OC_W'(OUT_CREDITS);
        end
        else
        begin
            result_valid <= take;
            if (take)
                drain_ptr <= (drain_ptr == LP_W'(NUM_LANES - 1)) ? '0 : drain_ptr + 1'b1;
            // credit is spent at pop time.
            case ({take, result_credit})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

endmodule

/* hw/exec_cluster.sv */
`timescale 1ns/10ps

module exec_cluster
    import exec_pkg::*;
#(
    parameter int NUM_LANES   = 4,
    parameter int IN_DEPTH    = 4,
    parameter int LANE_DEPTH  = 2,
    parameter int OUT_CREDITS = 2
)
(
    input  logic        clock,
    input  logic        reset,
    input  logic        op_valid,
    input  alu_req_t    op,
    output logic        op_credit,
    output logic        result_valid,
    output alu_result_t result,
    input  logic        result_credit
);

    logic [NUM_LANES-1:0] issue_valid;
    alu_req_t             issue_req;
    logic [NUM_LANES-1:0] lane_credit;
    logic [NUM_LANES-1:0] head_valid;
    alu_result_t          head_result [NUM_LANES];
    logic [NUM_LANES-1:0] pop;

    op_dispatcher #(
        .NUM_LANES  (NUM_LANES),
        .IN_DEPTH   (IN_DEPTH),
        .LANE_DEPTH (LANE_DEPTH)
    ) u_dispatcher (
        .clock       (clock),
        .reset       (reset),
        .op_valid    (op_valid),
        .op          (op),
        .op_credit   (op_credit),
        .issue_valid (issue_valid),
        .issue_req   (issue_req),
        .lane_credit (lane_credit)
    );

    // ************************************************************
    // lanes share one request bus, selected by issue_valid.
    // ************************************************************
    for (genvar i = 0; i < NUM_LANES; i++)
    begin : gen_lanes
        alu_lane #(
            .LANE_DEPTH (LANE_DEPTH)
        ) u_lane (
            .clock       (clock),
            .reset       (reset),
            .issue_valid (issue_valid[i]),
            .issue_req   (issue_req),
            .head_valid  (head_valid[i]),
            .head_result (head_result[i]),
            .pop         (pop[i]),
            .lane_credit (lane_credit[i])
        );
    end

    result_collector #(
        .NUM_LANES   (NUM_LANES),
        .OUT_CREDITS (OUT_CREDITS)
    ) u_collector (
        .clock         (clock),
        .reset         (reset),
        .head_valid    (head_valid),
        .head_result   (head_result),
        .pop           (pop),
        .result_valid  (result_valid),
        .result        (result),
        .result_credit (result_credit)
    );

endmodule

/* verification/exec_cluster_props.sv */
`timescale 1ns/10ps

module exec_cluster_props
#(
    parameter int NUM_LANES   = 4,
    parameter int LANE_DEPTH  = 2,
    parameter int OUT_CREDITS = 2
)
(
    input logic                 clock,
    input logic                 reset,
    input logic                 op_credit,
    input logic                 result_valid,
    input logic                 result_credit,
    input logic [NUM_LANES-1:0] issue_valid,
    input logic [NUM_LANES-1:0] lane_credit,
    input logic [NUM_LANES-1:0] pop
);

    int                   out_left;
    int                   lane_left [NUM_LANES];
    int                   fill [NUM_LANES];
    logic [NUM_LANES-1:0] push;
    logic                 reset_d;
    int                   failures = 0;

    // shadow counts of both credit loops and the lane FIFOs.
    always_ff @(posedge clock)
    begin
        reset_d <= reset;
        if (reset)
        begin
            out_left <= OUT_CREDITS;
            push     <= '0;
            for (int i = 0; i < NUM_LANES; i++)
            begin
                lane_left[i] <= LANE_DEPTH;
                fill[i]      <= 0;
            end
        end
        else
        begin
            out_left <= out_left - int'(result_valid) + int'(result_credit);
            push     <= issue_valid;
            for (int i = 0; i < NUM_LANES; i++)
            begin
                lane_left[i] <= lane_left[i] - int'(issue_valid[i]) + int'(lane_credit[i]);
                fill[i]      <= fill[i] + int'(push[i]) - int'(pop[i]);
            end
        end
    end

    assert property (@(posedge clock) disable iff (reset) result_valid |-> out_left > 0)
    else
    begin
        failures++;
        $error("result_valid with no output credit");
    end

    for (genvar i = 0; i < NUM_LANES; i++)
    begin : gen_lane_checks
        assert property (@(posedge clock) disable iff (reset)
            issue_valid[i] |-> lane_left[i] > 0)
        else
        begin
            failures++;
            $error("lane %0d issued without a credit", i);
        end
        assert property (@(posedge clock) disable iff (reset)
            push[i] |-> fill[i] < LANE_DEPTH)
        else
        begin
            failures++;
            $error("lane %0d FIFO pushed while full", i);
        end
    end

    assert property (@(posedge clock) (reset && reset_d) |->
        (!op_credit && !result_valid && issue_valid == '0 && pop == '0 && lane_credit == '0))
    else
    begin
        failures++;
        $error("control output active during reset");
    end

endmodule

bind exec_cluster exec_cluster_props #(
    .NUM_LANES   (NUM_LANES),
    .LANE_DEPTH  (LANE_DEPTH),
    .OUT_CREDITS (OUT_CREDITS)
) u_props (.*);

/* verification/tb_exec_cluster.sv */
`timescale 1ns/10ps

module tb_exec_cluster
    import exec_pkg::*;
();

    localparam int NUM_LANES   = 4;
    localparam int IN_DEPTH    = 4;
    localparam int LANE_DEPTH  = 2;
    localparam int OUT_CREDITS = 2;
    localparam int TIMEOUT     = 200;

    logic        clock = 1'b0;
    logic        reset = 1'b1;
    logic        op_valid = 1'b0;
    alu_req_t    op = '0;
    logic        op_credit;
    logic        result_valid;
    alu_result_t result;
    logic        result_credit = 1'b0;

    int          seed = 32'h3f6c_f05d;
    int          credits_back = 0;
    int          sent = 0;
    alu_req_t    req_q [$];
    alu_result_t exp_q [$];
    alu_result_t got_q [$];

    exec_cluster #(
        .NUM_LANES   (NUM_LANES),
        .IN_DEPTH    (IN_DEPTH),
        .LANE_DEPTH  (LANE_DEPTH),
        .OUT_CREDITS (OUT_CREDITS)
    ) dut (.*);

    always #10 clock = ~clock;

    // outputs sampled before the edge updates them.
    always @(posedge clock)
    begin
        if (!reset && op_credit)
            credits_back = credits_back + 1;
        if (!reset && result_valid)
            got_q.push_back(result);
    end

    // a failed bound assertion ends the run.
    always @(negedge clock)
    begin
        if (dut.u_props.failures != 0)
        begin
            $display("a bound assertion failed");
            $display("=== FAIL ===");
            $fatal(1);
        end
    end

    // ************************************************************
    // reference model, checking and handshakes.
    // ************************************************************
    function automatic alu_result_t expected_result(alu_req_t r);
        alu_result_t m = '0;
        logic [31:0] b = r.b;
        case (r.op)
            OP_ADD:       m.data = r.a + b;
            OP_SUB:       m.data = r.a - b;
            OP_SHL_ONES:  m.data = (b >= 32) ? '1 : (r.a << b) | ~(32'hffff_ffff << b);
            OP_SHR_ONES:  m.data = (b >= 32) ? '1 : (r.a >> b) | ~(32'hffff_ffff >> b);
            OP_MOVE:      m.data = r.a;
            OP_LOAD_HALF: m.data = b[16] ? {b[15:0], r.a[15:0]} : {r.a[31:16], b[15:0]};
            OP_CMP_EQ:    m.flag = (r.a == b);
            OP_CMP_LT:    m.flag = (r.a < b);
            OP_CMP_GT:    m.flag = (r.a > b);
            default:      m = '0;
        endcase
        return m;
    endfunction

    task automatic check_value(string name, logic [32:0] want, logic [32:0] got);
        if (want !== got)
        begin
            $display("[ERROR] %s: expected %h, actual %h", name, want, got);
            $display("=== FAIL ===");
            $fatal(1);
        end
    endtask

    task automatic report_timeout(string what);
        $display("timed out waiting for %s", what);
        $display("=== FAIL ===");
        $fatal(1);
    endtask

    function automatic void queue_op(alu_op_e o, logic [31:0] a, logic [31:0] b);
        alu_req_t r;
        r.op = o;
        r.a = a;
        r.b.word = b;
        req_q.push_back(r);
    endfunction

    task automatic send_req(alu_req_t r);
        int t = 0;
        while (IN_DEPTH + credits_back - sent <= 0)
        begin
            @(negedge clock);
            t++;
            if (t > TIMEOUT)
                report_timeout("an input credit");
        end
        op = r;
        op_valid = 1'b1;
        exp_q.push_back(expected_result(r));
        sent++;
        @(negedge clock);
        op_valid = 1'b0;
    endtask

    task automatic receive_results(string name, int count, int delay);
        alu_result_t want;
        alu_result_t got;
        int t;
        for (int k = 0; k < count; k++)
        begin
            t = 0;
            while (got_q.size() == 0)
            begin
                @(negedge clock);
                t++;
                if (t > TIMEOUT)
                    report_timeout("result_valid");
            end
            got = got_q.pop_front();
            want = exp_q.pop_front();
            check_value(name, want, got);
            repeat (delay) @(negedge clock);
            result_credit = 1'b1;
            @(negedge clock);
            result_credit = 1'b0;
        end
    endtask

    task automatic run_queued(string name, int delay);
        int n = req_q.size();
        fork
            while (req_q.size() != 0)
                send_req(req_q.pop_front());
            receive_results(name, n, delay);
        join
    endtask

    // ************************************************************
    // directed tests.
    // ************************************************************
    task automatic arith_and_move();
        queue_op(OP_ADD, 32'hffff_ffff, 32'h1);
        queue_op(OP_ADD, $random(seed), $random(seed));
        queue_op(OP_SUB, 32'h0, 32'h1);
        queue_op(OP_SUB, $random(seed), $random(seed));
        queue_op(OP_MOVE, 32'hffff_ffff, 32'h0);
        queue_op(OP_MOVE, $random(seed), $random(seed));
        run_queued("arith_and_move", 0);
    endtask

    task automatic ones_shifts();
        int amounts [4] = '{0, 1, 31, 40};
        for (int i = 0; i < 4; i++)
        begin
            queue_op(OP_SHL_ONES, $random(seed), amounts[i]);
            queue_op(OP_SHR_ONES, $random(seed), amounts[i]);
        end
        queue_op(OP_SHL_ONES, 32'h0, 32'd32);
        run_queued("ones_shifts", 0);
    endtask

    task automatic load_half_cases();
        queue_op(OP_LOAD_HALF, 32'h1234_5678, {15'h0, 1'b1, 16'hbeef});
        queue_op(OP_LOAD_HALF, 32'h1234_5678, {15'h7fff, 1'b0, 16'hbeef});
        queue_op(OP_LOAD_HALF, $random(seed), {15'h0, 1'b1, 16'h0});
        queue_op(OP_LOAD_HALF, $random(seed), {15'h0, 1'b0, 16'hffff});
        run_queued("load_half", 0);
    endtask

    task automatic compare_flags();
        logic [31:0] lhs [4] = '{32'd5, 32'd3, 32'd9, 32'hffff_ffff};
        logic [31:0] rhs [4] = '{32'd5, 32'd9, 32'd3, 32'd1};
        for (int i = 0; i < 4; i++)
        begin
            queue_op(OP_CMP_EQ, lhs[i], rhs[i]);
            queue_op(OP_CMP_LT, lhs[i], rhs[i]);
            queue_op(OP_CMP_GT, lhs[i], rhs[i]);
        end
        run_queued("compares", 0);
    endtask

    task automatic burst_in_order();
        alu_op_e mix [9] = '{OP_ADD, OP_SUB, OP_SHL_ONES, OP_SHR_ONES, OP_MOVE,
                             OP_LOAD_HALF, OP_CMP_EQ, OP_CMP_LT, OP_CMP_GT};
        for (int i = 0; i < 3 * NUM_LANES; i++)
            queue_op(mix[i % 9], $random(seed), $random(seed) & 32'h0001_003f);
        run_queued("burst_order", 0);
    endtask

    task automatic stall_and_resume();
        int cap = IN_DEPTH + NUM_LANES * LANE_DEPTH + OUT_CREDITS;
        int t = 0;
        for (int i = 0; i < cap; i++)
            send_req('{OP_ADD, $random(seed), i});
        while (got_q.size() < OUT_CREDITS)
        begin
            @(negedge clock);
            t++;
            if (t > TIMEOUT)
                report_timeout("the first results of the stall");
        end
        // nothing may move while credits are held back.
        repeat (4 * NUM_LANES) @(negedge clock);
        check_value("stall_results", OUT_CREDITS, got_q.size());
        check_value("stall_in_credits", 0, IN_DEPTH + credits_back - sent);
        receive_results("stall_resume", cap, 3);
    endtask

    initial
    begin
        repeat (10) @(negedge clock);
        reset = 1'b0;
        arith_and_move();
        ones_shifts();
        load_half_cases();
        compare_flags();
        burst_in_order();
        stall_and_resume();
        if (got_q.size() != 0 || exp_q.size() != 0)
        begin
            $display("results left over after the last test");
            $display("=== FAIL ===");
            $fatal(1);
        end
        else
        begin
            $display("=== PASS ===");
            $finish;
        end
    end

endmodule

/* filelist.f */
hw/exec_pkg.sv
hw/alu_lane.sv
hw/op_dispatcher.sv
hw/result_collector.sv
hw/exec_cluster.sv
verification/exec_cluster_props.sv
verification/tb_exec_cluster.sv
